// File: include/mem_bus_cfg.svh
`ifndef MEM_BUS_CFG_SVH
`define MEM_BUS_CFG_SVH

// bus and word geometry
`define MEM_ADDR_W      32
`define MEM_DATA_W      64
`define MEM_STRB_W      8
`define MEM_INST_W      32
`define MEM_DEPTH_LOG2  10

// access cycles, never below 1
`define MEM_LATENCY     2

// cacheable window of the core
`define MEM_WIN_BASE    32'h8000_0000
`define MEM_WIN_LAST    32'h87FF_FFFF

`define MEM_RESP_OKAY   2'd0
`define MEM_RESP_DECERR 2'd3

`endif

// File: hw/mem_bus_pkg.sv
`include "mem_bus_cfg.svh"

package mem_bus_pkg;

    // **************************************************
    // plain vector types
    // **************************************************
    typedef logic [`MEM_ADDR_W-1:0] addr_t;
    typedef logic [`MEM_DATA_W-1:0] data_t;
    typedef logic [`MEM_STRB_W-1:0] strb_t;
    typedef logic [`MEM_INST_W-1:0] inst_t;
    typedef logic [1:0]             resp_t;

    // wide enough to hold MEM_LATENCY-1, also for latency 1
    typedef logic [$clog2(`MEM_LATENCY + 1)-1:0] lat_cnt_t;

    // **************************************************
    // channel payloads
    // **************************************************
    // aw and w merged, the sram takes them together
    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
    } wr_req_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } rd_rsp_t;

    typedef struct packed {
        inst_t inst;
        resp_t resp;
    } inst_rsp_t;

    // arbiter states
    typedef enum logic [2:0] {
        IDLE,
        FETCH_WAIT,
        LOAD_WAIT,
        STORE_WAIT,
        FETCH_RSP,
        LOAD_RSP,
        STORE_RSP
    } arb_state_t;

    typedef enum logic [1:0] {
        GRANT_FETCH,
        GRANT_LOAD,
        GRANT_STORE
    } grant_t;

endpackage

// File: hw/bus_arbiter_fsm.sv
`timescale 1ns/10ps

module bus_arbiter_fsm (
    input  logic                clk,
    input  logic                rst_n,

    // request valids
    input  logic                if_ar_valid_i,
    input  logic                ls_ar_valid_i,
    input  logic                ls_aw_valid_i,

    // response readies
    input  logic                if_r_ready_i,
    input  logic                ls_r_ready_i,
    input  logic                ls_b_ready_i,

    input  logic                acc_done_i,

    output logic                if_ar_ready_o,
    output logic                ls_ar_ready_o,
    output logic                ls_aw_ready_o,
    output logic                if_r_valid_o,
    output logic                ls_r_valid_o,
    output logic                ls_b_valid_o,
    output logic                capture_o,
    output mem_bus_pkg::grant_t grant_o,
    output logic                acc_start_o
);

    mem_bus_pkg::arb_state_t state_q;
    mem_bus_pkg::arb_state_t state_d;
    logic                    idle;
    logic                    any_req;

    assign idle    = (state_q == mem_bus_pkg::IDLE);
    assign any_req = ls_aw_valid_i | ls_ar_valid_i | if_ar_valid_i;

    // **************************************************
    // request side, store > load > fetch
    // **************************************************
    // fetch is held off while data traffic is pending
    assign ls_aw_ready_o = idle & ls_aw_valid_i;
    assign ls_ar_ready_o = idle & ls_ar_valid_i & ~ls_aw_valid_i;
    assign if_ar_ready_o = idle & if_ar_valid_i & ~ls_aw_valid_i & ~ls_ar_valid_i;

    // one handshake per idle cycle, so capture and start coincide
    assign capture_o   = idle & any_req;
    assign acc_start_o = idle & any_req;

    always_comb begin
        if (ls_aw_valid_i) begin
            grant_o = mem_bus_pkg::GRANT_STORE;
        end else if (ls_ar_valid_i) begin
            grant_o = mem_bus_pkg::GRANT_LOAD;
        end else begin
            grant_o = mem_bus_pkg::GRANT_FETCH;
        end
    end

    // **************************************************
    // state transitions
    // **************************************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_bus_pkg::IDLE: begin
                // done can already arrive here when latency is 1
                if (any_req) begin
                    case (grant_o)
                        mem_bus_pkg::GRANT_STORE:
                            state_d = acc_done_i ? mem_bus_pkg::STORE_RSP
                                                 : mem_bus_pkg::STORE_WAIT;
                        mem_bus_pkg::GRANT_LOAD:
                            state_d = acc_done_i ? mem_bus_pkg::LOAD_RSP
                                                 : mem_bus_pkg::LOAD_WAIT;
                        default:
                            state_d = acc_done_i ? mem_bus_pkg::FETCH_RSP
                                                 : mem_bus_pkg::FETCH_WAIT;
                    endcase
                end
            end
            mem_bus_pkg::FETCH_WAIT: begin
                if (acc_done_i) state_d = mem_bus_pkg::FETCH_RSP;
            end
            mem_bus_pkg::LOAD_WAIT: begin
                if (acc_done_i) state_d = mem_bus_pkg::LOAD_RSP;
            end
            mem_bus_pkg::STORE_WAIT: begin
                if (acc_done_i) state_d = mem_bus_pkg::STORE_RSP;
            end
            // hold the response until the requester takes it
            mem_bus_pkg::FETCH_RSP: begin
                if (if_r_ready_i) state_d = mem_bus_pkg::IDLE;
            end
            mem_bus_pkg::LOAD_RSP: begin
                if (ls_r_ready_i) state_d = mem_bus_pkg::IDLE;
            end
            mem_bus_pkg::STORE_RSP: begin
                if (ls_b_ready_i) state_d = mem_bus_pkg::IDLE;
            end
            default: state_d = mem_bus_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q <= mem_bus_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // response valids straight from the state register
    assign if_r_valid_o = (state_q == mem_bus_pkg::FETCH_RSP);
    assign ls_r_valid_o = (state_q == mem_bus_pkg::LOAD_RSP);
    assign ls_b_valid_o = (state_q == mem_bus_pkg::STORE_RSP);

endmodule

// File: hw/access_latency_timer.sv
`timescale 1ns/10ps
`include "mem_bus_cfg.svh"

module access_latency_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic start_i,
    output logic done_o
);

    localparam mem_bus_pkg::lat_cnt_t LOAD_VAL = mem_bus_pkg::lat_cnt_t'(`MEM_LATENCY - 1);

    mem_bus_pkg::lat_cnt_t cnt_q;
    mem_bus_pkg::lat_cnt_t cnt_cur;
    logic                  busy_q;

    // start cycle counts as the first access cycle
    assign cnt_cur = start_i ? LOAD_VAL : cnt_q;
    assign done_o  = (start_i | busy_q) & (cnt_cur == '0);

    always_ff @(posedge clk) begin
        if (rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (done_o) begin
            busy_q <= 1'b0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            cnt_q  <= LOAD_VAL - 1'b1;
        end else if (busy_q) begin
            cnt_q  <= cnt_q - 1'b1;
        end
    end

endmodule

// File: hw/sram_bank.sv
`timescale 1ns/10ps
`include "mem_bus_cfg.svh"

module sram_bank (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   capture_i,
    input  mem_bus_pkg::grant_t    grant_i,
    input  mem_bus_pkg::addr_t     if_addr_i,
    input  mem_bus_pkg::addr_t     ls_rd_addr_i,
    input  mem_bus_pkg::wr_req_t   ls_wr_i,
    input  logic                   done_i,
    output mem_bus_pkg::rd_rsp_t   rsp_o,
    output mem_bus_pkg::inst_rsp_t inst_o
);

    localparam int unsigned WORDS = 2 ** `MEM_DEPTH_LOG2;
    localparam int unsigned OFS_W = $clog2(`MEM_STRB_W);

    mem_bus_pkg::data_t         mem [WORDS];
    mem_bus_pkg::wr_req_t       req_q;
    mem_bus_pkg::wr_req_t       req_new;
    mem_bus_pkg::wr_req_t       req_cur;
    mem_bus_pkg::grant_t        kind_q;
    mem_bus_pkg::grant_t        kind_cur;
    mem_bus_pkg::rd_rsp_t       rsp_q;
    logic [`MEM_DEPTH_LOG2-1:0] idx;
    logic                       in_win;

    // **************************************************
    // request latch
    // **************************************************
    always_comb begin
        req_new = ls_wr_i;
        if (grant_i == mem_bus_pkg::GRANT_FETCH) begin
            req_new.addr = if_addr_i;
            req_new.strb = '0;
        end else if (grant_i == mem_bus_pkg::GRANT_LOAD) begin
            req_new.addr = ls_rd_addr_i;
            req_new.strb = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            kind_q <= mem_bus_pkg::GRANT_FETCH;
        end else if (capture_i) begin
            kind_q <= grant_i;
        end
    end

    always_ff @(posedge clk) begin
        if (capture_i) req_q <= req_new;
    end

    // capture and done share an edge at latency 1
    assign req_cur  = capture_i ? req_new : req_q;
    assign kind_cur = capture_i ? grant_i : kind_q;

    assign idx    = req_cur.addr[OFS_W +: `MEM_DEPTH_LOG2];
    assign in_win = (req_cur.addr >= `MEM_WIN_BASE) && (req_cur.addr <= `MEM_WIN_LAST);

    // **************************************************
    // array access on done
    // **************************************************
    always_ff @(posedge clk) begin
        if (done_i) begin
            if (!in_win) begin
                // outside the window, memory stays untouched
                rsp_q.data <= '0;
                rsp_q.resp <= `MEM_RESP_DECERR;
            end else if (kind_cur == mem_bus_pkg::GRANT_STORE) begin
                for (int b = 0; b < `MEM_STRB_W; b++) begin
                    if (req_cur.strb[b]) mem[idx][b*8 +: 8] <= req_cur.data[b*8 +: 8];
                end
                rsp_q.data <= '0;
                rsp_q.resp <= `MEM_RESP_OKAY;
            end else begin
                rsp_q.data <= mem[idx];
                rsp_q.resp <= `MEM_RESP_OKAY;
            end
        end
    end

    assign rsp_o = rsp_q;

    // addr bit 2 picks the instruction half
    assign inst_o.inst = req_q.addr[2] ? rsp_q.data[`MEM_INST_W +: `MEM_INST_W]
                                       : rsp_q.data[0 +: `MEM_INST_W];
    assign inst_o.resp = rsp_q.resp;

endmodule

// File: hw/mem_bus_top.sv
`timescale 1ns/10ps

module mem_bus_top (
    input  logic                   clk,
    input  logic                   rst_n,

    // fetch read
    input  logic                   if_ar_valid_i,
    input  mem_bus_pkg::addr_t     if_ar_addr_i,
    output logic                   if_ar_ready_o,
    output logic                   if_r_valid_o,
    output mem_bus_pkg::inst_rsp_t if_r_o,
    input  logic                   if_r_ready_i,

    // load read
    input  logic                   ls_ar_valid_i,
    input  mem_bus_pkg::addr_t     ls_ar_addr_i,
    output logic                   ls_ar_ready_o,
    output logic                   ls_r_valid_o,
    output mem_bus_pkg::rd_rsp_t   ls_r_o,
    input  logic                   ls_r_ready_i,

    // store write, aw and w merged
    input  logic                   ls_aw_valid_i,
    input  mem_bus_pkg::wr_req_t   ls_aw_i,
    output logic                   ls_aw_ready_o,
    output logic                   ls_b_valid_o,
    output mem_bus_pkg::resp_t     ls_b_resp_o,
    input  logic                   ls_b_ready_i
);

    logic                 capture_w;
    mem_bus_pkg::grant_t  grant_w;
    logic                 acc_start_w;
    logic                 acc_done_w;
    mem_bus_pkg::rd_rsp_t rsp_w;

    bus_arbiter_fsm u_arbiter (
        .clk           (clk          ),
        .rst_n         (rst_n        ),
        .if_ar_valid_i (if_ar_valid_i),
        .ls_ar_valid_i (ls_ar_valid_i),
        .ls_aw_valid_i (ls_aw_valid_i),
        .if_r_ready_i  (if_r_ready_i ),
        .ls_r_ready_i  (ls_r_ready_i ),
        .ls_b_ready_i  (ls_b_ready_i ),
        .acc_done_i    (acc_done_w   ),
        .if_ar_ready_o (if_ar_ready_o),
        .ls_ar_ready_o (ls_ar_ready_o),
        .ls_aw_ready_o (ls_aw_ready_o),
        .if_r_valid_o  (if_r_valid_o ),
        .ls_r_valid_o  (ls_r_valid_o ),
        .ls_b_valid_o  (ls_b_valid_o ),
        .capture_o     (capture_w    ),
        .grant_o       (grant_w      ),
        .acc_start_o   (acc_start_w  )
    );

    access_latency_timer u_timer (
        .clk     (clk        ),
        .rst_n   (rst_n      ),
        .start_i (acc_start_w),
        .done_o  (acc_done_w )
    );

    sram_bank u_sram (
        .clk          (clk         ),
        .rst_n        (rst_n       ),
        .capture_i    (capture_w   ),
        .grant_i      (grant_w     ),
        .if_addr_i    (if_ar_addr_i),
        .ls_rd_addr_i (ls_ar_addr_i),
        .ls_wr_i      (ls_aw_i     ),
        .done_i       (acc_done_w  ),
        .rsp_o        (rsp_w       ),
        .inst_o       (if_r_o      )
    );

    // load and store responses share the bank's response register
    assign ls_r_o      = rsp_w;
    assign ls_b_resp_o = rsp_w.resp;

endmodule

// File: tb/mem_bus_properties.sv
`timescale 1ns/10ps
`include "mem_bus_cfg.svh"

module mem_bus_properties (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   if_ar_valid_i,
    input logic                   if_ar_ready_o,
    input logic                   ls_ar_valid_i,
    input logic                   ls_ar_ready_o,
    input logic                   ls_aw_valid_i,
    input logic                   ls_aw_ready_o,
    input logic                   if_r_valid_o,
    input logic                   if_r_ready_i,
    input mem_bus_pkg::inst_rsp_t if_r_o,
    input logic                   ls_r_valid_o,
    input logic                   ls_r_ready_i,
    input mem_bus_pkg::rd_rsp_t   ls_r_o,
    input logic                   ls_b_valid_o,
    input logic                   ls_b_ready_i,
    input mem_bus_pkg::resp_t     ls_b_resp_o,
    input logic                   acc_start_w,
    input logic                   acc_done_w
);

    logic rsp_busy;
    logic any_rdy;

    assign rsp_busy = if_r_valid_o | ls_r_valid_o | ls_b_valid_o;
    assign any_rdy  = if_ar_ready_o | ls_ar_ready_o | ls_aw_ready_o;

    // **************************************************
    // readies, store > load > fetch
    // **************************************************
    a_store_rdy: assert property (@(posedge clk) disable iff (rst_n)
        ls_aw_ready_o |-> ls_aw_valid_i) else $error("store ready without store valid");
    a_load_rdy: assert property (@(posedge clk) disable iff (rst_n)
        ls_ar_ready_o |-> ls_ar_valid_i && !ls_aw_valid_i)
        else $error("load ready without a winning load");
    a_fetch_rdy: assert property (@(posedge clk) disable iff (rst_n)
        if_ar_ready_o |-> if_ar_valid_i && !ls_ar_valid_i && !ls_aw_valid_i)
        else $error("fetch ready without a winning fetch");
    a_rdy_idle: assert property (@(posedge clk) disable iff (rst_n)
        rsp_busy |-> !any_rdy) else $error("ready raised while a response is pending");

    // response valid exactly MEM_LATENCY cycles after the handshake
    a_fetch_lat: assert property (@(posedge clk) disable iff (rst_n)
        if_ar_valid_i && if_ar_ready_o |-> ##`MEM_LATENCY $rose(if_r_valid_o))
        else $error("fetch response latency wrong");
    a_load_lat: assert property (@(posedge clk) disable iff (rst_n)
        ls_ar_valid_i && ls_ar_ready_o |-> ##`MEM_LATENCY $rose(ls_r_valid_o))
        else $error("load response latency wrong");
    a_store_lat: assert property (@(posedge clk) disable iff (rst_n)
        ls_aw_valid_i && ls_aw_ready_o |-> ##`MEM_LATENCY $rose(ls_b_valid_o))
        else $error("store response latency wrong");

    // **************************************************
    // back-pressure
    // **************************************************
    a_fetch_hold: assert property (@(posedge clk) disable iff (rst_n)
        if_r_valid_o && !if_r_ready_i |=> if_r_valid_o && $stable(if_r_o))
        else $error("fetch response changed under back-pressure");
    a_load_hold: assert property (@(posedge clk) disable iff (rst_n)
        ls_r_valid_o && !ls_r_ready_i |=> ls_r_valid_o && $stable(ls_r_o))
        else $error("load response changed under back-pressure");
    a_store_hold: assert property (@(posedge clk) disable iff (rst_n)
        ls_b_valid_o && !ls_b_ready_i |=> ls_b_valid_o && $stable(ls_b_resp_o))
        else $error("store response changed under back-pressure");

    // timer never restarted mid access
    a_timer_done: assert property (@(posedge clk) disable iff (rst_n)
        acc_start_w |-> ##(`MEM_LATENCY - 1) acc_done_w) else $error("timer done misplaced");
    a_timer_once: assert property (@(posedge clk) disable iff (rst_n)
        acc_start_w |=> !acc_start_w) else $error("timer started while counting");

endmodule

bind mem_bus_top mem_bus_properties u_props (.*);

// File: tb/tb_mem_bus.sv
`timescale 1ns/10ps
`include "mem_bus_cfg.svh"

module tb_mem_bus;

    localparam int WAIT_LIMIT = 64;
    localparam int OFS        = $clog2(`MEM_STRB_W);

    logic                   clk;
    logic                   rst_n;
    logic                   if_ar_valid_i;
    mem_bus_pkg::addr_t     if_ar_addr_i;
    logic                   if_ar_ready_o;
    logic                   if_r_valid_o;
    mem_bus_pkg::inst_rsp_t if_r_o;
    logic                   if_r_ready_i;
    logic                   ls_ar_valid_i;
    mem_bus_pkg::addr_t     ls_ar_addr_i;
    logic                   ls_ar_ready_o;
    logic                   ls_r_valid_o;
    mem_bus_pkg::rd_rsp_t   ls_r_o;
    logic                   ls_r_ready_i;
    logic                   ls_aw_valid_i;
    mem_bus_pkg::wr_req_t   ls_aw_i;
    logic                   ls_aw_ready_o;
    logic                   ls_b_valid_o;
    mem_bus_pkg::resp_t     ls_b_resp_o;
    logic                   ls_b_ready_i;

    // scoreboard by array index
    mem_bus_pkg::data_t     sb [int unsigned];
    mem_bus_pkg::addr_t     addrs [$];
    // last response taken
    mem_bus_pkg::rd_rsp_t   got_rd;
    mem_bus_pkg::inst_rsp_t got_inst;
    mem_bus_pkg::resp_t     got_b;

    mem_bus_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // **************************************************
    // checking helpers
    // **************************************************
    task automatic stop_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic in_window(input mem_bus_pkg::addr_t a);
        return (a >= `MEM_WIN_BASE) && (a <= `MEM_WIN_LAST);
    endfunction

    function automatic int unsigned word_idx(input mem_bus_pkg::addr_t a);
        return 32'(a[OFS +: `MEM_DEPTH_LOG2]);
    endfunction

    function automatic mem_bus_pkg::data_t sb_word(input mem_bus_pkg::addr_t a);
        return sb.exists(word_idx(a)) ? sb[word_idx(a)] : '0;
    endfunction

    function automatic mem_bus_pkg::addr_t rand_win_addr();
        return `MEM_WIN_BASE | ($urandom & (`MEM_WIN_LAST - `MEM_WIN_BASE) & ~32'h7);
    endfunction

    // channel 0 is fetch, 1 is load and 2 is store
    function automatic logic req_ready(input int ch);
        return (ch == 0) ? if_ar_ready_o : (ch == 1) ? ls_ar_ready_o : ls_aw_ready_o;
    endfunction

    function automatic logic rsp_valid(input int ch);
        return (ch == 0) ? if_r_valid_o : (ch == 1) ? ls_r_valid_o : ls_b_valid_o;
    endfunction

    task automatic set_rsp_ready(input int ch, input logic v);
        case (ch)
            0:       if_r_ready_i = v;
            1:       ls_r_ready_i = v;
            default: ls_b_ready_i = v;
        endcase
    endtask

    // **************************************************
    // handshake tasks enter and leave on a falling edge
    // **************************************************
    task automatic wait_ready(input int ch, input string name);
        int n;
        n = 0;
        #1;
        while (!req_ready(ch)) begin
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout waiting for %s", name);
                stop_run();
            end
            @(negedge clk);
            #1;
        end
        check_val("request readies onehot",
                  64'($onehot0({if_ar_ready_o, ls_ar_ready_o, ls_aw_ready_o})), 64'd1);
        @(negedge clk);
    endtask

    task automatic take_rsp(input int ch, input string name);
        int n;
        int hold;
        n = 0;
        #1;
        while (!rsp_valid(ch)) begin
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout waiting for %s", name);
                stop_run();
            end
            @(negedge clk);
            #1;
        end
        // random back-pressure before taking it
        hold = $urandom_range(3, 0);
        repeat (hold + 1) @(negedge clk);
        set_rsp_ready(ch, 1'b1);
        #1;
        check_val(name, 64'(rsp_valid(ch)), 64'd1);
        got_rd   = ls_r_o;
        got_inst = if_r_o;
        got_b    = ls_b_resp_o;
        @(negedge clk);
        set_rsp_ready(ch, 1'b0);
    endtask

    task automatic write_word(input mem_bus_pkg::addr_t a, input mem_bus_pkg::data_t d,
                              input mem_bus_pkg::strb_t s);
        mem_bus_pkg::data_t merged;
        merged = sb_word(a);
        ls_aw_valid_i = 1'b1;
        ls_aw_i.addr  = a;
        ls_aw_i.data  = d;
        ls_aw_i.strb  = s;
        wait_ready(2, "ls_aw_ready_o");
        ls_aw_valid_i = 1'b0;
        take_rsp(2, "ls_b_valid_o");
        check_val("ls_b_resp_o", 64'(got_b),
                  in_window(a) ? 64'(`MEM_RESP_OKAY) : 64'(`MEM_RESP_DECERR));
        if (in_window(a)) begin
            for (int b = 0; b < `MEM_STRB_W; b++) begin
                if (s[b]) merged[b*8 +: 8] = d[b*8 +: 8];
            end
            sb[word_idx(a)] = merged;
        end
    endtask

    task automatic read_word(input mem_bus_pkg::addr_t a);
        ls_ar_valid_i = 1'b1;
        ls_ar_addr_i  = a;
        wait_ready(1, "ls_ar_ready_o");
        ls_ar_valid_i = 1'b0;
        take_rsp(1, "ls_r_valid_o");
        check_val("ls_r_o.data", got_rd.data, in_window(a) ? sb_word(a) : 64'd0);
        check_val("ls_r_o.resp", 64'(got_rd.resp),
                  in_window(a) ? 64'(`MEM_RESP_OKAY) : 64'(`MEM_RESP_DECERR));
    endtask

    task automatic fetch_inst(input mem_bus_pkg::addr_t a);
        mem_bus_pkg::data_t w;
        w = in_window(a) ? sb_word(a) : '0;
        if_ar_valid_i = 1'b1;
        if_ar_addr_i  = a;
        wait_ready(0, "if_ar_ready_o");
        if_ar_valid_i = 1'b0;
        take_rsp(0, "if_r_valid_o");
        check_val("if_r_o.inst", 64'(got_inst.inst), a[2] ? 64'(w[63:32]) : 64'(w[31:0]));
        check_val("if_r_o.resp", 64'(got_inst.resp),
                  in_window(a) ? 64'(`MEM_RESP_OKAY) : 64'(`MEM_RESP_DECERR));
    endtask

    // **************************************************
    // test sequence
    // **************************************************
    initial begin
        void'($urandom(32'hce8f_b4f6));
        rst_n         = 1'b1;
        if_ar_valid_i = 1'b0;
        if_ar_addr_i  = '0;
        if_r_ready_i  = 1'b0;
        ls_ar_valid_i = 1'b0;
        ls_ar_addr_i  = '0;
        ls_r_ready_i  = 1'b0;
        ls_aw_valid_i = 1'b0;
        ls_aw_i       = '0;
        ls_b_ready_i  = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b0;

        // quiet bus after reset
        repeat (8) begin
            @(negedge clk);
            #1;
            check_val("response valids", 64'({if_r_valid_o, ls_r_valid_o, ls_b_valid_o}), 64'd0);
            check_val("request readies", 64'({if_ar_ready_o, ls_ar_ready_o, ls_aw_ready_o}), 64'd0);
        end
        @(negedge clk);

        // full words first and then one partial merge
        for (int i = 0; i < 8; i++) begin
            addrs.push_back(rand_win_addr());
            write_word(addrs[i], {$urandom, $urandom}, '1);
        end
        write_word(addrs[0], {$urandom, $urandom}, (8'($urandom) | 8'h21) & 8'h7F);
        foreach (addrs[i]) read_word(addrs[i]);

        // both instruction halves
        fetch_inst(addrs[1] & ~32'h4);
        fetch_inst(addrs[1] | 32'h4);

        // load beats a waiting fetch
        if_ar_valid_i = 1'b1;
        if_ar_addr_i  = addrs[2] | 32'h4;
        read_word(addrs[3]);
        fetch_inst(addrs[2] | 32'h4);

        // store beats a load to the same word
        ls_ar_valid_i = 1'b1;
        ls_ar_addr_i  = addrs[4];
        write_word(addrs[4], {$urandom, $urandom}, '1);
        read_word(addrs[4]);

        // aliasing stores outside the window leave memory alone
        read_word(32'h0000_1000);
        fetch_inst(32'h9000_0004);
        write_word(32'h9000_0000 | (addrs[5] & 32'h0000_1FF8), {$urandom, $urandom}, '1);
        write_word(32'h7FFF_FFF8, {$urandom, $urandom}, '1);
        read_word(addrs[5]);

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: files.f
+incdir+include
hw/mem_bus_pkg.sv
hw/bus_arbiter_fsm.sv
hw/access_latency_timer.sv
hw/sram_bank.sv
hw/mem_bus_top.sv
tb/mem_bus_properties.sv
tb/tb_mem_bus.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory bus testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 -f files.f \
    --top-module tb_mem_bus --Mdir obj_dir -o tb_mem_bus
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_mem_bus > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
echo "simulation passed"
exit 0
